//--- rtl/isaPkg.sv
`default_nettype none

package isaPkg;

	////////////////////
	// Main page opcodes, real LR35902 encodings
	typedef enum logic [7:0] {
		ocNop = 8'h00,
		ocLdBN = 8'h06, ocLdCN = 8'h0E, ocLdDN = 8'h16, ocLdEN = 8'h1E,
		ocLdHN = 8'h26, ocLdLN = 8'h2E, ocLdAN = 8'h3E,
		ocIncB = 8'h04, ocIncC = 8'h0C, ocIncD = 8'h14, ocIncE = 8'h1C,
		ocIncH = 8'h24, ocIncL = 8'h2C, ocIncA = 8'h3C,
		ocDecB = 8'h05, ocDecC = 8'h0D, ocDecD = 8'h15, ocDecE = 8'h1D,
		ocDecH = 8'h25, ocDecL = 8'h2D, ocDecA = 8'h3D,
		ocLdHlB = 8'h70, ocLdHlC = 8'h71, ocLdHlD = 8'h72, ocLdHlE = 8'h73,
		ocLdHlH = 8'h74, ocLdHlL = 8'h75, ocLdHlA = 8'h77,
		ocAddB = 8'h80, ocAddC = 8'h81, ocAddD = 8'h82, ocAddE = 8'h83,
		ocAddH = 8'h84, ocAddL = 8'h85, ocAddA = 8'h87,
		ocSubB = 8'h90, ocSubC = 8'h91, ocSubD = 8'h92, ocSubE = 8'h93,
		ocSubH = 8'h94, ocSubL = 8'h95, ocSubA = 8'h97,
		ocJr = 8'h18,
		ocJrNz = 8'h20,
		ocCb = 8'hCB
	} opcode_t;

	// CB page
	typedef enum logic [7:0] {
		cbRrB = 8'h18, cbRrC = 8'h19, cbRrD = 8'h1A, cbRrE = 8'h1B,
		cbRrH = 8'h1C, cbRrL = 8'h1D, cbRrA = 8'h1F,
		cbSrlB = 8'h38
	} cbOpcode_t;

	// Opcode register field order; slot 6 is (HL) in the ISA, decoded register in microcode
	typedef enum logic [2:0] {
		regB = 3'd0, regC = 3'd1, regD = 3'd2, regE = 3'd3,
		regH = 3'd4, regL = 3'd5, regFromDec = 3'd6, regA = 3'd7
	} reg8_t;

	typedef struct packed {
		logic zero;
		logic carry;
	} flags_t;

endpackage

`default_nettype wire

//--- rtl/ucodePkg.sv
`default_nettype none

package ucodePkg;

	typedef logic [6:0] flowIdx_t;

	// Sequencer action per micro-op
	typedef enum logic [2:0] {
		uNext,
		uInc,
		uEof,
		uIncEof,
		uIncEofZ
	} uopNext_t;

	// Datapath operations
	typedef enum logic [3:0] {
		opNop, opSetMemAddr, opMemWrite, opRegFromMem,
		opInc8, opDec8, opAdd8, opSub8,
		opRr8, opSrl8, opJumpRel
	} uopOp_t;

	typedef enum logic [3:0] {
		selPc,
		selHl,
		selX8,
		selReg
	} uopSel_t;

	typedef struct packed {
		uopNext_t next;
		uopOp_t op;
		uopSel_t sel;
		isaPkg::reg8_t regIdx;
	} uop_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] wdata;
		logic we;
	} memReq_t;

	////////////////////
	// Flow start rows
	localparam flowIdx_t flowFetch = 7'd0;
	localparam flowIdx_t flowNop = 7'd1;
	localparam flowIdx_t flowLdRn = 7'd2;
	localparam flowIdx_t flowInc = 7'd5;
	localparam flowIdx_t flowDec = 7'd7;
	localparam flowIdx_t flowAdd = 7'd9;
	localparam flowIdx_t flowSub = 7'd11;
	localparam flowIdx_t flowLdHlR = 7'd13;
	localparam flowIdx_t flowJr = 7'd16;
	localparam flowIdx_t flowJrNz = 7'd20;
	localparam flowIdx_t flowRr = 7'd24;
	localparam flowIdx_t flowSrl = 7'd26;
	// Last populated row
	localparam flowIdx_t flowLast = 7'd27;

endpackage

`default_nettype wire

//--- rtl/mainDecode.sv
`timescale 1ns/1ps
`default_nettype none

module mainDecode (
	input  isaPkg::opcode_t opcode,
	output ucodePkg::flowIdx_t flowStart,
	output isaPkg::reg8_t regIdx
);
	import isaPkg::*;
	import ucodePkg::*;

	reg8_t dstField;
	reg8_t srcField;

	// Register operand sits in bits 5:3 or 2:0 depending on the group
	assign dstField = reg8_t'(opcode[5:3]);
	assign srcField = reg8_t'(opcode[2:0]);

	always_comb
	begin
		flowStart = flowNop;
		regIdx = regA;
		case (opcode)
			ocNop: flowStart = flowNop;
			ocLdBN, ocLdCN, ocLdDN, ocLdEN, ocLdHN, ocLdLN, ocLdAN:
			begin
				flowStart = flowLdRn;
				regIdx = dstField;
			end
			ocIncB, ocIncC, ocIncD, ocIncE, ocIncH, ocIncL, ocIncA:
			begin
				flowStart = flowInc;
				regIdx = dstField;
			end
			ocDecB, ocDecC, ocDecD, ocDecE, ocDecH, ocDecL, ocDecA:
			begin
				flowStart = flowDec;
				regIdx = dstField;
			end
			ocLdHlB, ocLdHlC, ocLdHlD, ocLdHlE, ocLdHlH, ocLdHlL, ocLdHlA:
			begin
				flowStart = flowLdHlR;
				regIdx = srcField;
			end
			ocAddB, ocAddC, ocAddD, ocAddE, ocAddH, ocAddL, ocAddA:
			begin
				flowStart = flowAdd;
				regIdx = srcField;
			end
			ocSubB, ocSubC, ocSubD, ocSubE, ocSubH, ocSubL, ocSubA:
			begin
				flowStart = flowSub;
				regIdx = srcField;
			end
			ocJr: flowStart = flowJr;
			ocJrNz: flowStart = flowJrNz;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/cbDecode.sv
`timescale 1ns/1ps
`default_nettype none

module cbDecode (
	input  isaPkg::cbOpcode_t opcode,
	output ucodePkg::flowIdx_t flowStart,
	output isaPkg::reg8_t regIdx
);
	import isaPkg::*;
	import ucodePkg::*;

	reg8_t srcField;

	// CB page keeps its register in the low bits
	assign srcField = reg8_t'(opcode[2:0]);

	always_comb
	begin
		flowStart = flowNop;
		regIdx = srcField;
		case (opcode)
			cbRrB, cbRrC, cbRrD, cbRrE, cbRrH, cbRrL, cbRrA: flowStart = flowRr;
			cbSrlB: flowStart = flowSrl;
			default: regIdx = regA;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/ucodeRom.sv
`timescale 1ns/1ps
`default_nettype none

module ucodeRom (
	input  ucodePkg::flowIdx_t flowIdx,
	output ucodePkg::uop_t uop
);
	import isaPkg::*;
	import ucodePkg::*;

	always_comb
	begin
		case (flowIdx)
			// Opcode fetch
			flowFetch:        uop = '{uNext, opSetMemAddr, selPc, regA};
			// NOP
			flowNop:          uop = '{uIncEof, opNop, selPc, regA};

			////////////////////
			// LD r,n: step onto the immediate, address it, take it next cycle
			flowLdRn:         uop = '{uInc, opNop, selPc, regA};
			flowLdRn + 7'd1:  uop = '{uNext, opSetMemAddr, selPc, regA};
			flowLdRn + 7'd2:  uop = '{uIncEof, opRegFromMem, selReg, regFromDec};
			// INC r
			flowInc:          uop = '{uNext, opInc8, selReg, regFromDec};
			flowInc + 7'd1:   uop = '{uIncEof, opNop, selPc, regA};
			// DEC r
			flowDec:          uop = '{uNext, opDec8, selReg, regFromDec};
			flowDec + 7'd1:   uop = '{uIncEof, opNop, selPc, regA};
			// ADD A,r
			flowAdd:          uop = '{uNext, opAdd8, selReg, regFromDec};
			flowAdd + 7'd1:   uop = '{uIncEof, opNop, selPc, regA};
			// SUB A,r
			flowSub:          uop = '{uNext, opSub8, selReg, regFromDec};
			flowSub + 7'd1:   uop = '{uIncEof, opNop, selPc, regA};
			// LD (HL),r then put PC back on the bus
			flowLdHlR:        uop = '{uInc, opSetMemAddr, selHl, regA};
			flowLdHlR + 7'd1: uop = '{uNext, opMemWrite, selReg, regFromDec};
			flowLdHlR + 7'd2: uop = '{uEof, opSetMemAddr, selPc, regA};

			////////////////////
			// JR n, offset is relative to the next opcode
			flowJr:           uop = '{uInc, opNop, selPc, regA};
			flowJr + 7'd1:    uop = '{uNext, opSetMemAddr, selPc, regA};
			flowJr + 7'd2:    uop = '{uInc, opRegFromMem, selX8, regA};
			flowJr + 7'd3:    uop = '{uEof, opJumpRel, selX8, regA};
			// JR NZ,n: falls out at the offset row when Z is set
			flowJrNz:         uop = '{uInc, opNop, selPc, regA};
			flowJrNz + 7'd1:  uop = '{uNext, opSetMemAddr, selPc, regA};
			flowJrNz + 7'd2:  uop = '{uIncEofZ, opRegFromMem, selX8, regA};
			flowJrNz + 7'd3:  uop = '{uEof, opJumpRel, selX8, regA};

			////////////////////
			// CB RR r
			flowRr:           uop = '{uNext, opRr8, selReg, regFromDec};
			flowRr + 7'd1:    uop = '{uIncEof, opNop, selPc, regA};
			// CB SRL
			flowSrl:          uop = '{uNext, opSrl8, selReg, regFromDec};
			flowSrl + 7'd1:   uop = '{uIncEof, opNop, selPc, regA};
			default:          uop = '{uEof, opNop, selPc, regA};
		endcase
	end

	// Sequencer should never step past the last populated row
	always_comb
	begin
		if (!$isunknown(flowIdx))
			romRange: assert #0 (flowIdx <= flowLast)
				else $error("flowIdx %0d hits an unused ROM row", flowIdx);
	end

endmodule

`default_nettype wire

//--- rtl/ucodeSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ucodeSequencer (
	input  logic clock,
	input  logic rst,
	input  logic [7:0] memRdata,
	input  ucodePkg::flowIdx_t mainStart,
	input  ucodePkg::flowIdx_t cbStart,
	input  isaPkg::reg8_t mainReg,
	input  isaPkg::reg8_t cbReg,
	input  isaPkg::flags_t flags,
	input  ucodePkg::uop_t uop,
	output ucodePkg::flowIdx_t flowIdx,
	output isaPkg::reg8_t curReg,
	output logic [7:0] fetchOpcode,
	output logic incPc
);
	import isaPkg::*;
	import ucodePkg::*;

	typedef enum logic [1:0] {
		seqFetch,
		seqWait,
		seqRun,
		seqCbWait
	} seqState_t;

	seqState_t state;
	logic cbPage;
	logic isCbPrefix;
	logic endFlow;
	logic startFlow;

	// Opcode byte arrives one cycle after the fetch address
	assign fetchOpcode = memRdata;
	assign isCbPrefix = (memRdata == ocCb);

	assign endFlow = (uop.next inside {uEof, uIncEof}) || (uop.next == uIncEofZ && flags.zero);
	assign startFlow = (state == seqWait && !isCbPrefix) || (state == seqCbWait);

	// CB prefix moves PC onto the second opcode byte
	assign incPc = (state == seqRun && (uop.next inside {uInc, uIncEof, uIncEofZ}))
		|| (state == seqWait && isCbPrefix);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= seqFetch;
			flowIdx <= flowFetch;
			cbPage <= 1'b0;
		end
		else
		begin
			case (state)
				seqFetch: state <= cbPage ? seqCbWait : seqWait;
				seqWait:
					if (isCbPrefix)
					begin
						cbPage <= 1'b1;
						state <= seqFetch;
					end
					else
					begin
						flowIdx <= mainStart;
						state <= seqRun;
					end
				seqCbWait:
				begin
					cbPage <= 1'b0;
					flowIdx <= cbStart;
					state <= seqRun;
				end
				default:
					if (endFlow)
					begin
						flowIdx <= flowFetch;
						state <= seqFetch;
					end
					else
						flowIdx <= flowIdx + 7'd1;
			endcase
		end
	end

	// Register field follows whichever page was decoded
	always_ff @(posedge clock)
	begin
		if (state == seqWait)
			curReg <= mainReg;
		else if (state == seqCbWait)
			curReg <= cbReg;
	end

	// Every decoded flow terminates within eight micro-ops
	flowEnds: assert property (@(posedge clock) disable iff (rst)
		startFlow |=> ##[0:7] (state == seqRun && endFlow))
		else $error("microcode flow ran past eight micro-ops");

endmodule

`default_nettype wire

//--- rtl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
	parameter logic [15:0] resetPc = 16'h0100
) (
	input  logic clock,
	input  logic rst,
	input  ucodePkg::uop_t uop,
	input  isaPkg::reg8_t curReg,
	input  logic incPc,
	input  logic [7:0] memRdata,
	output isaPkg::flags_t flags,
	output ucodePkg::memReq_t mem
);
	import isaPkg::*;
	import ucodePkg::*;

	logic [7:0] regs [8];
	logic [15:0] pc;
	logic [15:0] addrReg;
	logic [7:0] x8;
	reg8_t tgt;
	reg8_t dst;
	logic [7:0] operand;
	logic [15:0] addrSel;
	logic [7:0] aluRes;
	logic aluCarry;

	////////////////////
	// Operand selection
	assign tgt = (uop.regIdx == regFromDec) ? curReg : uop.regIdx;
	assign dst = (uop.op inside {opAdd8, opSub8}) ? regA : tgt;
	assign operand = (uop.sel == selX8) ? x8 : regs[tgt];
	assign addrSel = (uop.sel == selHl) ? {regs[regH], regs[regL]} : pc;

	// ALU
	always_comb
	begin
		aluRes = operand;
		aluCarry = flags.carry;
		case (uop.op)
			opInc8: aluRes = operand + 8'd1;
			opDec8: aluRes = operand - 8'd1;
			opAdd8: {aluCarry, aluRes} = {1'b0, regs[regA]} + {1'b0, operand};
			// Borrow lands in bit 8
			opSub8: {aluCarry, aluRes} = {1'b0, regs[regA]} - {1'b0, operand};
			opRr8: {aluRes, aluCarry} = {flags.carry, operand};
			opSrl8: {aluRes, aluCarry} = {1'b0, operand};
			default: ;
		endcase
	end

	// Address goes out in the same cycle as setMemAddr
	always_comb
	begin
		mem.addr = (uop.op == opSetMemAddr) ? addrSel : addrReg;
		mem.wdata = operand;
		mem.we = (uop.op == opMemWrite);
	end

	////////////////////
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			pc <= resetPc;
			addrReg <= resetPc;
			flags <= '0;
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (incPc)
				pc <= pc + 16'd1;
			case (uop.op)
				opSetMemAddr: addrReg <= addrSel;
				opRegFromMem:
					if (uop.sel != selX8)
						regs[tgt] <= memRdata;
				// INC and DEC leave carry alone
				opInc8, opDec8:
				begin
					regs[dst] <= aluRes;
					flags.zero <= (aluRes == 8'd0);
				end
				opAdd8, opSub8, opRr8, opSrl8:
				begin
					regs[dst] <= aluRes;
					flags <= '{zero: (aluRes == 8'd0), carry: aluCarry};
				end
				// PC is already past the offset byte here
				opJumpRel: pc <= pc + {{8{x8[7]}}, x8};
				default: ;
			endcase
		end
	end

	// Jump offset
	always_ff @(posedge clock)
	begin
		if (uop.op == opRegFromMem && uop.sel == selX8)
			x8 <= memRdata;
	end

	// A store always follows an HL address setup, so it never hits a fetch address
	storeAfterHl: assert property (@(posedge clock) disable iff (rst)
		mem.we |-> $past(uop.op == opSetMemAddr && uop.sel == selHl))
		else $error("store without an HL address setup");

endmodule

`default_nettype wire

//--- rtl/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
	parameter logic [15:0] resetPc = 16'h0100
) (
	input  logic clock,
	input  logic rst,
	input  logic [7:0] memRdata,
	output ucodePkg::memReq_t mem
);
	import isaPkg::*;
	import ucodePkg::*;

	logic [7:0] fetchOpcode;
	flowIdx_t mainStart;
	flowIdx_t cbStart;
	flowIdx_t flowIdx;
	reg8_t mainReg;
	reg8_t cbReg;
	reg8_t curReg;
	flags_t flags;
	uop_t uop;
	logic incPc;

	////////////////////
	// Both pages decode the same byte
	mainDecode mainDec (
		.opcode(opcode_t'(fetchOpcode)),
		.flowStart(mainStart),
		.regIdx(mainReg)
	);

	cbDecode cbDec (
		.opcode(cbOpcode_t'(fetchOpcode)),
		.flowStart(cbStart),
		.regIdx(cbReg)
	);

	ucodeSequencer seq (
		.clock(clock),
		.rst(rst),
		.memRdata(memRdata),
		.mainStart(mainStart),
		.cbStart(cbStart),
		.mainReg(mainReg),
		.cbReg(cbReg),
		.flags(flags),
		.uop(uop),
		.flowIdx(flowIdx),
		.curReg(curReg),
		.fetchOpcode(fetchOpcode),
		.incPc(incPc)
	);

	ucodeRom rom (
		.flowIdx(flowIdx),
		.uop(uop)
	);

	datapath #(
		.resetPc(resetPc)
	) dp (
		.clock(clock),
		.rst(rst),
		.uop(uop),
		.curReg(curReg),
		.incPc(incPc),
		.memRdata(memRdata),
		.flags(flags),
		.mem(mem)
	);

endmodule

`default_nettype wire

//--- tests/tbCpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbCpuCore;
	import ucodePkg::*;

	localparam logic [15:0] resetPc = 16'h0100;
	localparam int clockPeriod = 4;
	localparam int numTests = 4;
	localparam int maxBytes = 48;
	localparam int maxWrites = 8;
	localparam int settleCycles = 20;

	////////////////////
	// Programs, loaded at resetPc; each one parks on JR -2
	// LD r,n and LD (HL),r for all seven registers
	localparam progLoadStore = {8'h26, 8'h01, 8'h2E, 8'hF0,
		8'h06, 8'h11, 8'h70, 8'h0E, 8'h22, 8'h71, 8'h16, 8'h33, 8'h72,
		8'h1E, 8'h44, 8'h73, 8'h3E, 8'h55, 8'h77, 8'h2E, 8'hE8, 8'h75,
		8'h26, 8'h01, 8'h74, 8'h18, 8'hFE};
	localparam writesLoadStore = {24'h01F011, 24'h01F022, 24'h01F033, 24'h01F044,
		24'h01F055, 24'h01E8E8, 24'h01E801};
	// INC, DEC, ADD and SUB with wrap, carry and borrow
	localparam progAlu = {8'h26, 8'h01, 8'h2E, 8'hF0,
		8'h3E, 8'hFF, 8'h3C, 8'h77, 8'h06, 8'h00, 8'h05, 8'h70,
		8'h0E, 8'h05, 8'h0C, 8'h71, 8'h3E, 8'hF0, 8'h81, 8'h77,
		8'h16, 8'h10, 8'h82, 8'h77, 8'h92, 8'h77,
		8'h1E, 8'h0A, 8'h1D, 8'h73, 8'h93, 8'h77, 8'h18, 8'hFE};
	localparam writesAlu = {24'h01F000, 24'h01F0FF, 24'h01F006, 24'h01F0F6,
		24'h01F006, 24'h01F0F6, 24'h01F009, 24'h01F0ED};
	// DEC loop closed by JR NZ, then JR +1 over a store
	localparam progLoop = {8'h26, 8'h01, 8'h2E, 8'hF0, 8'h3E, 8'h5A,
		8'h06, 8'h03, 8'h05, 8'h70, 8'h20, 8'hFC,
		8'h18, 8'h01, 8'h70, 8'h77, 8'h18, 8'hFE};
	localparam writesLoop = {24'h01F002, 24'h01F001, 24'h01F000, 24'h01F05A};
	// CB page: RR through a cleared carry, SRL, then RR through a set carry
	localparam progCbPage = {8'h26, 8'h01, 8'h2E, 8'hF0,
		8'h3E, 8'hF0, 8'h87, 8'h97, 8'h77,
		8'h0E, 8'h02, 8'hCB, 8'h19, 8'h71,
		8'h06, 8'h81, 8'hCB, 8'h38, 8'h70,
		8'h0E, 8'h02, 8'hCB, 8'h19, 8'h71, 8'h18, 8'hFE};
	localparam writesCbPage = {24'h01F000, 24'h01F001, 24'h01F040, 24'h01F081};

	localparam int totalBytes = ($bits(progLoadStore) + $bits(progAlu)
		+ $bits(progLoop) + $bits(progCbPage)) / 8;

	logic clock;
	logic rst;
	logic [7:0] memRdata;
	memReq_t memOut;

	logic [8*maxBytes-1:0] progTable [numTests];
	int progLen [numTests];
	logic [24*maxWrites-1:0] writeTable [numTests];
	int writeCount [numTests];

	logic [7:0] memArray [256];
	logic [15:0] lastAddr;
	logic [23:0] expWrite;
	int curTest;
	int writeIdx;
	int checks;
	int errors;

	cpuCore #(
		.resetPc(resetPc)
	) dut (
		.clock(clock),
		.rst(rst),
		.memRdata(memRdata),
		.mem(memOut)
	);

	initial
	begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		if (actual !== expected)
		begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	function automatic logic [7:0] readByte(input logic [15:0] addr);
		if (addr[15:8] == resetPc[15:8])
			return memArray[addr[7:0]];
		return 8'h00;
	endfunction

	task automatic loadMemory(input int t);
		for (int i = 0; i < 256; i++)
			memArray[i] = i[7:0] ^ 8'hA5;
		for (int i = 0; i < progLen[t]; i++)
			memArray[i] = progTable[t][8*(progLen[t]-1-i) +: 8];
	endtask

	////////////////////
	// Memory with one cycle of read latency, plus the write checker
	always @(negedge clock)
	begin
		memRdata <= readByte(lastAddr);
		lastAddr = memOut.addr;
		if (memOut.we === 1'b1)
		begin
			if (writeIdx < writeCount[curTest])
			begin
				expWrite = writeTable[curTest][24*(writeCount[curTest]-1-writeIdx) +: 24];
				checkValue("mem.addr", expWrite[23:8], memOut.addr);
				checkValue("mem.wdata", {8'h00, expWrite[7:0]}, {8'h00, memOut.wdata});
			end
			else
			begin
				$display("Test %0d: unexpected extra write of %h to %h at %0t ns",
					curTest, memOut.wdata, memOut.addr, $time);
				errors++;
			end
			writeIdx++;
			if (memOut.addr[15:8] == resetPc[15:8])
				memArray[memOut.addr[7:0]] = memOut.wdata;
		end
	end

	task automatic runTest(input int t);
		int limit;
		int cycles;
		@(negedge clock);
		rst = 1'b1;
		@(posedge clock);
		loadMemory(t);
		curTest = t;
		writeIdx = 0;
		repeat (10) @(negedge clock);
		checkValue("mem.we", 16'h0000, {15'h0000, memOut.we});
		rst = 1'b0;
		// First cycle out of reset fetches from resetPc
		@(negedge clock);
		checkValue("mem.addr", resetPc, memOut.addr);
		checkValue("mem.we", 16'h0000, {15'h0000, memOut.we});
		limit = 20 * progLen[t];
		cycles = 0;
		while (writeIdx < writeCount[t] && cycles < limit)
		begin
			@(posedge clock);
			cycles++;
		end
		if (writeIdx < writeCount[t])
		begin
			$display("Test %0d: only %0d of %0d expected writes arrived",
				t, writeIdx, writeCount[t]);
			errors++;
		end
		// Parked program must stay quiet
		repeat (settleCycles) @(posedge clock);
	endtask

	initial
	begin
		rst = 1'b1;
		memRdata = 8'h00;
		lastAddr = resetPc;
		curTest = 0;
		writeIdx = 0;
		checks = 0;
		errors = 0;
		progTable[0] = progLoadStore;
		progLen[0] = $bits(progLoadStore) / 8;
		writeTable[0] = writesLoadStore;
		writeCount[0] = $bits(writesLoadStore) / 24;
		progTable[1] = progAlu;
		progLen[1] = $bits(progAlu) / 8;
		writeTable[1] = writesAlu;
		writeCount[1] = $bits(writesAlu) / 24;
		progTable[2] = progLoop;
		progLen[2] = $bits(progLoop) / 8;
		writeTable[2] = writesLoop;
		writeCount[2] = $bits(writesLoop) / 24;
		progTable[3] = progCbPage;
		progLen[3] = $bits(progCbPage) / 8;
		writeTable[3] = writesCbPage;
		writeCount[3] = $bits(writesCbPage) / 24;

		for (int t = 0; t < numTests; t++)
			runTest(t);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	////////////////////
	// Watchdog, 40 cycles per program byte over all tests
	initial
	begin
		#(totalBytes * 40 * clockPeriod);
		$display("Timeout: the run did not finish within %0d cycles", totalBytes * 40);
		errors++;
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
rtl/isaPkg.sv
rtl/ucodePkg.sv
rtl/mainDecode.sv
rtl/cbDecode.sv
rtl/ucodeRom.sv
rtl/ucodeSequencer.sv
rtl/datapath.sv
rtl/cpuCore.sv
tests/tbCpuCore.sv
